// File: verilog/yolo_write_pkg.sv
package yolo_write_pkg;

   // widths
   localparam int data_w   = 32;
   localparam int addr_w   = 16;
   localparam int cnt_w    = 8;
   localparam int shift_w  = 5;
   localparam int credit_w = 3;

   // credits held after reset
   localparam logic [credit_w-1:0] rd_credits = 3'd4;
   localparam logic [credit_w-1:0] wr_credits = 3'd2;

   // extra right shift for negative values in leaky relu
   localparam int leaky_shift = 3;

   // host register map
   typedef enum logic [3:0] {
      rd_start  = 4'd0,
      rd_iter   = 4'd1,
      rd_per    = 4'd2,
      rd_shift  = 4'd3,
      rd_incr   = 4'd4,
      wr_start  = 4'd5,
      weight    = 4'd6,
      bias      = 4'd7,
      act_shift = 4'd8,
      // bit 0 bias enable, bit 1 leaky enable
      act_flags = 4'd9
   } cfg_reg_e;

   typedef struct packed {
      logic              valid;
      cfg_reg_e          addr;
      logic [data_w-1:0] data;
   } cfg_wr_t;

   typedef struct packed {
      logic [addr_w-1:0]        rd_start;
      logic [cnt_w-1:0]         rd_iter;
      logic [cnt_w-1:0]         rd_per;
      logic [addr_w-1:0]        rd_shift;
      logic [addr_w-1:0]        rd_incr;
      logic [addr_w-1:0]        wr_start;
      logic signed [data_w-1:0] weight;
      logic signed [data_w-1:0] bias;
      logic [shift_w-1:0]       act_shift;
      logic                     bias_en;
      logic                     leaky_en;
   } cfg_t;

   typedef struct packed {
      logic              valid;
      logic [addr_w-1:0] addr;
   } rd_req_t;

   typedef struct packed {
      logic              valid;
      logic [data_w-1:0] data;
   } rd_rsp_t;

   typedef struct packed {
      logic              valid;
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] data;
   } wr_req_t;

endpackage

// File: verilog/yolo_write_cfg.sv
module yolo_write_cfg (
   input  logic                    clk,
   input  logic                    rst,
   input  yolo_write_pkg::cfg_wr_t cfg_wr,
   input  logic                    run,
   output yolo_write_pkg::cfg_t    cfg
);

   // working copy written by the host
   yolo_write_pkg::cfg_t work;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         work <= '0;
      end else if (cfg_wr.valid) begin
         case (cfg_wr.addr)
            yolo_write_pkg::rd_start:
               work.rd_start <= cfg_wr.data[yolo_write_pkg::addr_w-1:0];
            yolo_write_pkg::rd_iter:
               work.rd_iter <= cfg_wr.data[yolo_write_pkg::cnt_w-1:0];
            yolo_write_pkg::rd_per:
               work.rd_per <= cfg_wr.data[yolo_write_pkg::cnt_w-1:0];
            yolo_write_pkg::rd_shift:
               work.rd_shift <= cfg_wr.data[yolo_write_pkg::addr_w-1:0];
            yolo_write_pkg::rd_incr:
               work.rd_incr <= cfg_wr.data[yolo_write_pkg::addr_w-1:0];
            yolo_write_pkg::wr_start:
               work.wr_start <= cfg_wr.data[yolo_write_pkg::addr_w-1:0];
            yolo_write_pkg::weight:
               work.weight <= cfg_wr.data;
            yolo_write_pkg::bias:
               work.bias <= cfg_wr.data;
            yolo_write_pkg::act_shift:
               work.act_shift <= cfg_wr.data[yolo_write_pkg::shift_w-1:0];
            yolo_write_pkg::act_flags: begin
               work.bias_en  <= cfg_wr.data[0];
               work.leaky_en <= cfg_wr.data[1];
            end
            default: begin
            end
         endcase
      end
   end

   // shadow copy frozen for the whole run
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         cfg <= '0;
      end else if (run) begin
         cfg <= work;
      end
   end

endmodule

// File: verilog/yolo_read_gen.sv
module yolo_read_gen (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    run,
   input  yolo_write_pkg::cfg_t    cfg,
   input  logic                    hold,
   input  logic                    rd_credit,
   output yolo_write_pkg::rd_req_t rd_req
);

   typedef enum logic {s_idle, s_busy} state_e;

   state_e                                state;
   logic [yolo_write_pkg::cnt_w-1:0]      win_cnt;
   logic [yolo_write_pkg::cnt_w-1:0]      word_cnt;
   logic [yolo_write_pkg::addr_w-1:0]     win_off;
   logic [yolo_write_pkg::addr_w-1:0]     word_off;
   logic [yolo_write_pkg::credit_w-1:0]   credits;
   logic                                  empty_cfg;
   logic                                  last_word;
   logic                                  last_win;
   logic                                  fire;

   assign empty_cfg = (cfg.rd_iter == '0) || (cfg.rd_per == '0);
   assign last_word = word_cnt == cfg.rd_per - 1'b1;
   assign last_win  = win_cnt == cfg.rd_iter - 1'b1;

   // a new window waits while results are still queued
   assign fire = (state == s_busy) && !empty_cfg && (credits != '0) &&
                 !((word_cnt == '0) && hold);

   assign rd_req.valid = fire;
   assign rd_req.addr  = cfg.rd_start + win_off + word_off;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         credits <= yolo_write_pkg::rd_credits;
      end else begin
         case ({fire, rd_credit})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state    <= s_idle;
         win_cnt  <= '0;
         word_cnt <= '0;
         win_off  <= '0;
         word_off <= '0;
      end else if (run) begin
         state    <= s_busy;
         win_cnt  <= '0;
         word_cnt <= '0;
         win_off  <= '0;
         word_off <= '0;
      end else if (state == s_busy) begin
         if (empty_cfg) begin
            state <= s_idle;
         end else if (fire) begin
            if (last_word) begin
               word_cnt <= '0;
               word_off <= '0;
               win_cnt  <= win_cnt + 1'b1;
               win_off  <= win_off + cfg.rd_shift;
               if (last_win) begin
                  state <= s_idle;
               end
            end else begin
               word_cnt <= word_cnt + 1'b1;
               word_off <= word_off + cfg.rd_incr;
            end
         end
      end
   end

endmodule

// File: verilog/yolo_write_addr.sv
module yolo_write_addr (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              run,
   input  yolo_write_pkg::cfg_t              cfg,
   input  logic                              wr_credit,
   input  logic                              wr_take,
   output logic                              wr_slot,
   output logic [yolo_write_pkg::addr_w-1:0] wr_addr,
   output logic                              done
);

   typedef enum logic {s_idle, s_busy} state_e;

   state_e                                state;
   logic [yolo_write_pkg::cnt_w-1:0]      issued;
   logic [yolo_write_pkg::cnt_w-1:0]      next_issued;
   logic [yolo_write_pkg::credit_w-1:0]   credits;

   assign next_issued = wr_take ? issued + 1'b1 : issued;
   assign wr_slot     = credits != '0;
   assign wr_addr     = cfg.wr_start +
                        {{(yolo_write_pkg::addr_w - yolo_write_pkg::cnt_w){1'b0}}, issued};

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         credits <= yolo_write_pkg::wr_credits;
      end else begin
         case ({wr_take, wr_credit})
            2'b10:   credits <= credits - 1'b1;
            2'b01:   credits <= credits + 1'b1;
            default: credits <= credits;
         endcase
      end
   end

   // done goes up right after the last write is taken
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state  <= s_idle;
         issued <= '0;
         done   <= 1'b0;
      end else if (run) begin
         state  <= s_busy;
         issued <= '0;
         done   <= 1'b0;
      end else if (state == s_busy) begin
         issued <= next_issued;
         if (next_issued == cfg.rd_iter) begin
            state <= s_idle;
            done  <= 1'b1;
         end
      end
   end

endmodule

// File: verilog/yolo_act.sv
module yolo_act (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              run,
   input  yolo_write_pkg::cfg_t              cfg,
   input  yolo_write_pkg::rd_rsp_t           rd_rsp,
   input  logic                              wr_slot,
   input  logic [yolo_write_pkg::addr_w-1:0] wr_addr,
   output logic                              hold,
   output logic                              wr_take,
   output yolo_write_pkg::wr_req_t           wr_req
);

   logic signed [yolo_write_pkg::data_w-1:0] acc;
   logic signed [yolo_write_pkg::data_w-1:0] prod;
   logic signed [yolo_write_pkg::data_w-1:0] sum;
   logic signed [yolo_write_pkg::data_w-1:0] biased;
   logic signed [yolo_write_pkg::data_w-1:0] scaled;
   logic signed [yolo_write_pkg::data_w-1:0] result;
   logic [yolo_write_pkg::cnt_w-1:0]         word_cnt;
   logic                                     win_end;

   // two-entry result queue
   logic [yolo_write_pkg::data_w-1:0]        q_data [2];
   logic                                     wr_ptr;
   logic                                     rd_ptr;
   logic [1:0]                               q_cnt;

   assign prod    = $signed(rd_rsp.data) * $signed(cfg.weight);
   // first word of a window restarts the sum
   assign sum     = (word_cnt == '0) ? prod : acc + prod;
   assign win_end = rd_rsp.valid && (word_cnt == cfg.rd_per - 1'b1);

   assign biased = cfg.bias_en ? sum + $signed(cfg.bias) : sum;
   assign scaled = biased >>> cfg.act_shift;
   assign result = (cfg.leaky_en && scaled[yolo_write_pkg::data_w-1]) ?
                   scaled >>> yolo_write_pkg::leaky_shift : scaled;

   assign hold    = q_cnt != 2'd0;
   assign wr_take = hold && wr_slot;

   assign wr_req.valid = wr_take;
   assign wr_req.addr  = wr_addr;
   assign wr_req.data  = q_data[rd_ptr];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         word_cnt <= '0;
      end else if (run) begin
         word_cnt <= '0;
      end else if (rd_rsp.valid) begin
         if (win_end) begin
            word_cnt <= '0;
         end else begin
            word_cnt <= word_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rd_rsp.valid) begin
         acc <= sum;
      end
      if (win_end) begin
         q_data[wr_ptr] <= result;
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         wr_ptr <= 1'b0;
         rd_ptr <= 1'b0;
         q_cnt  <= 2'd0;
      end else begin
         if (win_end) begin
            wr_ptr <= ~wr_ptr;
         end
         if (wr_take) begin
            rd_ptr <= ~rd_ptr;
         end
         case ({win_end, wr_take})
            2'b10:   q_cnt <= q_cnt + 1'b1;
            2'b01:   q_cnt <= q_cnt - 1'b1;
            default: q_cnt <= q_cnt;
         endcase
      end
   end

endmodule

// File: verilog/yolo_write.sv
module yolo_write (
   input  logic                    clk,
   input  logic                    rst,
   input  yolo_write_pkg::cfg_wr_t cfg_wr,
   input  logic                    run,
   output yolo_write_pkg::rd_req_t rd_req,
   input  yolo_write_pkg::rd_rsp_t rd_rsp,
   input  logic                    rd_credit,
   output yolo_write_pkg::wr_req_t wr_req,
   input  logic                    wr_credit,
   output logic                    done
);

   yolo_write_pkg::cfg_t              cfg;
   logic                              hold;
   logic                              wr_slot;
   logic                              wr_take;
   logic [yolo_write_pkg::addr_w-1:0] wr_addr;

   yolo_write_cfg u_cfg (
      .clk    (clk),
      .rst    (rst),
      .cfg_wr (cfg_wr),
      .run    (run),
      .cfg    (cfg)
   );

   yolo_read_gen u_read_gen (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .cfg       (cfg),
      .hold      (hold),
      .rd_credit (rd_credit),
      .rd_req    (rd_req)
   );

   // write side runs next to the reader
   yolo_write_addr u_write_addr (
      .clk       (clk),
      .rst       (rst),
      .run       (run),
      .cfg       (cfg),
      .wr_credit (wr_credit),
      .wr_take   (wr_take),
      .wr_slot   (wr_slot),
      .wr_addr   (wr_addr),
      .done      (done)
   );

   yolo_act u_act (
      .clk     (clk),
      .rst     (rst),
      .run     (run),
      .cfg     (cfg),
      .rd_rsp  (rd_rsp),
      .wr_slot (wr_slot),
      .wr_addr (wr_addr),
      .hold    (hold),
      .wr_take (wr_take),
      .wr_req  (wr_req)
   );

endmodule

// File: test/tb_yolo_write.sv
module tb_yolo_write;

   localparam int total_words = 80;
   localparam int cycle_limit = 40 * total_words + 200;

   logic                    clk = 1'b0;
   logic                    rst;
   logic                    run;
   logic                    rd_credit;
   logic                    wr_credit;
   logic                    done;
   yolo_write_pkg::cfg_wr_t cfg_wr;
   yolo_write_pkg::rd_req_t rd_req;
   yolo_write_pkg::rd_rsp_t rd_rsp;
   yolo_write_pkg::wr_req_t wr_req;

   int          mem [65536];
   int          work_v [10];
   int          shadow_v [10];
   logic [15:0] exp_rd_addr [$];
   logic [15:0] exp_wr_addr [$];
   int          exp_wr_data [$];
   int          rsp_q [$];
   int          rd_out = 0;
   int          wr_out = 0;
   int          rd_pend = 0;
   int          wr_pend = 0;
   int          wr_count = 0;
   int          cycles = 0;
   int          lag = 2;
   logic        done_exp = 1'b0;

   yolo_write dut (
      .clk       (clk),
      .rst       (rst),
      .cfg_wr    (cfg_wr),
      .run       (run),
      .rd_req    (rd_req),
      .rd_rsp    (rd_rsp),
      .rd_credit (rd_credit),
      .wr_req    (wr_req),
      .wr_credit (wr_credit),
      .done      (done)
   );

   always #2 clk = ~clk;

   task automatic report_error(input string msg);
      $display("FAIL %0t: %s", $time, msg);
      $display("Regression failed");
      $fatal(1);
   endtask

   always @(posedge clk) begin
      cycles++;
      if (cycles > cycle_limit) begin
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("Regression failed");
         $fatal(1);
      end
   end

   // outputs sampled before the edge updates them
   always @(posedge clk) begin
      if (!rst) begin
         assert (done == done_exp) else report_error("done flag mismatch");
         if (run) begin
            done_exp = 1'b0;
            wr_count = 0;
         end
         if (rd_req.valid) begin
            assert (rd_out < 4) else report_error("read issued without credit");
            assert (exp_rd_addr.size() > 0) else report_error("unexpected read request");
            assert (rd_req.addr == exp_rd_addr[0]) else report_error("wrong read address");
            void'(exp_rd_addr.pop_front());
            rsp_q.push_back(mem[rd_req.addr]);
            rd_pend++;
         end
         rd_out = rd_out + (rd_req.valid ? 1 : 0) - (rd_credit ? 1 : 0);
         if (wr_req.valid) begin
            assert (wr_out < 2) else report_error("write issued without credit");
            assert (exp_wr_data.size() > 0) else report_error("unexpected write request");
            assert (wr_req.addr == exp_wr_addr[0]) else report_error("wrong write address");
            assert (wr_req.data == exp_wr_data[0]) else report_error("wrong write data");
            void'(exp_wr_addr.pop_front());
            void'(exp_wr_data.pop_front());
            wr_pend++;
            wr_count++;
            if (wr_count == shadow_v[1][7:0]) begin
               done_exp = 1'b1;
            end
         end
         wr_out = wr_out + (wr_req.valid ? 1 : 0) - (wr_credit ? 1 : 0);
      end
   end

   // memory model returning responses in order and credits with random lag
   always @(negedge clk) begin
      rd_rsp    <= '0;
      rd_credit <= 1'b0;
      wr_credit <= 1'b0;
      if (!rst) begin
         if (rsp_q.size() > 0 && ($urandom % 3) != 0) begin
            rd_rsp.valid <= 1'b1;
            rd_rsp.data  <= rsp_q.pop_front();
         end
         if (rd_pend > 0 && ($urandom % lag) == 0) begin
            rd_credit <= 1'b1;
            rd_pend--;
         end
         if (wr_pend > 0 && ($urandom % lag) == 0) begin
            wr_credit <= 1'b1;
            wr_pend--;
         end
      end
   end

   task automatic write_reg(input yolo_write_pkg::cfg_reg_e a, input int d);
      cfg_wr.valid = 1'b1;
      cfg_wr.addr  = a;
      cfg_wr.data  = d;
      work_v[int'(a)] = d;
      @(negedge clk);
      cfg_wr = '0;
   endtask

   task automatic expect_run();
      logic [15:0] a;
      int          acc;
      for (int i = 0; i < shadow_v[1][7:0]; i++) begin
         acc = 0;
         for (int j = 0; j < shadow_v[2][7:0]; j++) begin
            a = shadow_v[0][15:0] + i * shadow_v[3][15:0] + j * shadow_v[4][15:0];
            exp_rd_addr.push_back(a);
            acc = acc + mem[a] * shadow_v[6];
         end
         if (shadow_v[9][0]) begin
            acc = acc + shadow_v[7];
         end
         acc = acc >>> shadow_v[8][4:0];
         if (shadow_v[9][1] && acc < 0) begin
            acc = acc >>> yolo_write_pkg::leaky_shift;
         end
         exp_wr_data.push_back(acc);
         exp_wr_addr.push_back(shadow_v[5][15:0] + i[15:0]);
      end
   endtask

   task automatic start_run();
      shadow_v = work_v;
      expect_run();
      run = 1'b1;
      @(negedge clk);
      run = 1'b0;
   endtask

   task automatic wait_done();
      while (!(done === 1'b1 && exp_wr_data.size() == 0)) begin
         @(negedge clk);
      end
   endtask

   task automatic set_config(input int st, input int it, input int per, input int sh,
                             input int inc, input int w, input int b, input int ash,
                             input int flags);
      write_reg(yolo_write_pkg::rd_start, st);
      write_reg(yolo_write_pkg::rd_iter, it);
      write_reg(yolo_write_pkg::rd_per, per);
      write_reg(yolo_write_pkg::rd_shift, sh);
      write_reg(yolo_write_pkg::rd_incr, inc);
      write_reg(yolo_write_pkg::weight, w);
      write_reg(yolo_write_pkg::bias, b);
      write_reg(yolo_write_pkg::act_shift, ash);
      write_reg(yolo_write_pkg::act_flags, flags);
   endtask

   initial begin
      void'($urandom(96));
      rst    = 1'b1;
      run    = 1'b0;
      cfg_wr = '0;
      rd_rsp = '0;
      rd_credit = 1'b0;
      wr_credit = 1'b0;
      for (int k = 0; k < 10; k++) begin
         work_v[k] = 0;
      end
      for (int k = 0; k < 65536; k++) begin
         mem[k] = int'($urandom % 2001) - 1000;
      end
      repeat (10) @(posedge clk);
      @(negedge clk);
      assert (!rd_req.valid && !wr_req.valid && !done)
         else report_error("outputs active after reset");
      rst = 1'b0;
      write_reg(yolo_write_pkg::wr_start, 2000);
      // bias on, leaky off
      set_config(100, 4, 5, 7, 1, 3, 50, 2, 1);
      start_run();
      wait_done();
      // leaky with negative weight
      set_config(65530, 3, 6, 20, 3, -5, 11, 1, 3);
      start_run();
      wait_done();
      set_config(300, 5, 3, 4, 2, 7, -20, 3, 1);
      start_run();
      // changes during the run apply only to the next one
      write_reg(yolo_write_pkg::weight, 9);
      write_reg(yolo_write_pkg::bias, -77);
      write_reg(yolo_write_pkg::wr_start, 4000);
      wait_done();
      start_run();
      wait_done();
      // slow credit return
      lag = 8;
      set_config(1000, 6, 2, 9, 5, -2, 3, 0, 2);
      start_run();
      wait_done();
      repeat (5) @(negedge clk);
      assert (done) else report_error("done dropped without a new run");
      $display("Regression passed");
      $finish;
   end

endmodule

// File: yolo_write.f
verilog/yolo_write_pkg.sv
verilog/yolo_write_cfg.sv
verilog/yolo_read_gen.sv
verilog/yolo_write_addr.sv
verilog/yolo_act.sv
verilog/yolo_write.sv
test/tb_yolo_write.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary -f yolo_write.f --top-module tb_yolo_write -o sim_yolo_write

./obj_dir/sim_yolo_write > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression passed" sim.log; then
   exit 0
fi
exit 1
